// ==== files.f ====
hw/mmu_pkg.sv
hw/tlb_entry.sv
hw/tlb_refill_ctrl.sv
hw/tlb_resolver.sv
hw/sv32_mmu_top.sv
verification/mmu_assertions.sv
verification/tb_sv32_mmu.sv

// ==== Makefile ====
# Verilator build and run for the Sv32 data TLB

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_sv32_mmu
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_sv32_mmu.sv ====
// ----------------------------------------------------------------------
// testbench for the Sv32 data TLB
// shadow TLB with reference lookup, response compare, watchdog
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tb_sv32_mmu;

  localparam int unsigned NUM_ENTRIES  = 8;
  // requests issued by all tests together
  localparam int unsigned PLANNED_REQS = 176;
  // pte flag byte is d a g u x w r v
  localparam logic [7:0] F_RWAD = 8'hc7;
  // full, user, no A, read only, execute only, no D
  localparam logic [7:0] PERM_FLAGS [6] = '{8'hc7, 8'hd7, 8'h87, 8'h43, 8'h49, 8'h47};

  logic                      clk_i;
  logic                      rst_ni;
  mmu_pkg::lookup_req_t      req;
  mmu_pkg::mmu_ctrl_t        ctrl;
  mmu_pkg::tlb_refill_t      refill;
  mmu_pkg::tlb_flush_t       flush;
  logic                      hit;
  logic [mmu_pkg::PPN_W-1:0] ppn;
  mmu_pkg::lookup_rsp_t      rsp;

  logic                 sh_valid [NUM_ENTRIES];
  mmu_pkg::tlb_refill_t sh_entry [NUM_ENTRIES];
  int                   sh_ptr;
  mmu_pkg::lookup_rsp_t exp_q [$];
  logic [19:0]          pg_vpn [16];
  logic                 pg_mega [16];
  int                   checks;
  int                   errors;
  int                   mark_checks;
  int                   mark_errors;

  sv32_mmu_top #(.NUM_ENTRIES (NUM_ENTRIES)) UUT (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req),
    .ctrl_i   (ctrl),
    .refill_i (refill),
    .flush_i  (flush),
    .hit_o    (hit),
    .ppn_o    (ppn),
    .rsp_o    (rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ---------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------
  function automatic mmu_pkg::lookup_rsp_t ref_lookup(input mmu_pkg::lookup_req_t r,
      input mmu_pkg::mmu_ctrl_t c, output logic e_hit, output logic [21:0] e_ppn);
    mmu_pkg::lookup_rsp_t e;
    mmu_pkg::tlb_refill_t t;
    logic [19:0] vpn;
    logic        priv_err;
    logic        fault;
    e       = '0;
    e.valid = 1'b1;
    e.cause = mmu_pkg::CAUSE_NONE;
    t       = '0;
    vpn     = r.vaddr[31:12];
    e_hit   = 1'b1;
    e_ppn   = {2'b00, vpn};
    if (!c.en_translation || c.priv == mmu_pkg::PRIV_M) begin
      e.paddr = {2'b00, r.vaddr};
      return e;
    end
    e_hit = 1'b0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (sh_valid[i] && (sh_entry[i].pte.g || sh_entry[i].asid == c.asid) &&
          vpn[19:10] == sh_entry[i].vpn[19:10] &&
          (sh_entry[i].is_mega || vpn[9:0] == sh_entry[i].vpn[9:0])) begin
        e_hit = 1'b1;
        t     = sh_entry[i];
      end
    end
    e.miss = !e_hit;
    if (!e_hit) begin
      return e;
    end
    e_ppn   = t.is_mega ? {t.pte.ppn[21:10], vpn[9:0]} : t.pte.ppn;
    e.paddr = t.is_mega ? {t.pte.ppn[21:10], r.vaddr[21:0]} : {t.pte.ppn, r.vaddr[11:0]};
    priv_err = (c.priv == mmu_pkg::PRIV_U && !t.pte.u) ||
               (c.priv == mmu_pkg::PRIV_S && t.pte.u && !c.sum);
    fault = r.is_store ? (!t.pte.a || !t.pte.w || !t.pte.d || priv_err)
                       : (!t.pte.a || !(t.pte.r || (c.mxr && t.pte.x)) || priv_err);
    if (fault) begin
      e.exc_valid = 1'b1;
      e.cause     = r.is_store ? mmu_pkg::CAUSE_ST_PAGE_FAULT : mmu_pkg::CAUSE_LD_PAGE_FAULT;
    end
    return e;
  endfunction

  // victim comes from the valid bits before the flush, the refill still lands
  function automatic void shadow_update(input mmu_pkg::tlb_refill_t f,
                                        input mmu_pkg::tlb_flush_t fl);
    int          victim;
    logic [19:0] fvpn;
    victim = -1;
    fvpn   = fl.vaddr[31:12];
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!sh_valid[i]) begin
        victim = i;
      end
    end
    if (f.valid && victim < 0) begin
      victim = sh_ptr;
      sh_ptr = (sh_ptr + 1) % NUM_ENTRIES;
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (fl.valid && (fl.asid == '0 || (fl.asid == sh_entry[i].asid && !sh_entry[i].pte.g)) &&
          (fl.vaddr == '0 || (fvpn[19:10] == sh_entry[i].vpn[19:10] &&
           (sh_entry[i].is_mega || fvpn[9:0] == sh_entry[i].vpn[9:0])))) begin
        sh_valid[i] = 1'b0;
      end
    end
    if (f.valid) begin
      sh_valid[victim] = 1'b1;
      sh_entry[victim] = f;
    end
  endfunction

  // outputs are stable at the falling edge
  always @(negedge clk_i) begin : compare
    mmu_pkg::lookup_rsp_t e;
    logic                 e_hit;
    logic [21:0]          e_ppn;
    if (rst_ni) begin
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        checks++;
        assert (rsp === e) else begin
          $display("mismatch at %0t: rsp %h, expected %h", $time, rsp, e);
          errors++;
        end
      end else begin
        assert (!rsp.valid) else begin
          $display("response valid without a request at %0t", $time);
          errors++;
        end
      end
      if (req.valid) begin
        e = ref_lookup(req, ctrl, e_hit, e_ppn);
        exp_q.push_back(e);
        checks++;
        assert (hit === e_hit && (!e_hit || ppn === e_ppn)) else begin
          $display("mismatch at %0t: va %h hit %b ppn %h, expected hit %b ppn %h",
                   $time, req.vaddr, hit, ppn, e_hit, e_ppn);
          errors++;
        end
      end
      shadow_update(refill, flush);
    end
  end

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  task automatic drive(input mmu_pkg::lookup_req_t r, input mmu_pkg::tlb_refill_t f,
                       input mmu_pkg::tlb_flush_t fl);
    @(posedge clk_i);
    req    <= r;
    refill <= f;
    flush  <= fl;
  endtask

  task automatic lookup(input logic [31:0] va, input logic st);
    drive('{1'b1, va, st}, '0, '0);
  endtask

  task automatic flush_tlb(input logic [8:0] asid, input logic [31:0] va);
    drive('0, '0, '{1'b1, asid, va});
  endtask

  task automatic set_ctrl(input logic en, input mmu_pkg::priv_lvl_e priv, input logic sum,
                          input logic mxr, input logic [8:0] asid);
    @(posedge clk_i);
    ctrl   <= '{en, priv, sum, mxr, asid};
    req    <= '0;
    refill <= '0;
    flush  <= '0;
  endtask

  task automatic add_page(input int j, input logic [9:0] top, input logic mega,
                          input logic [8:0] asid, input logic [7:0] flags);
    logic [31:0] rnd;
    rnd        = $urandom;
    pg_vpn[j]  = {top, rnd[9:0]};
    pg_mega[j] = mega;
    drive('0, '{1'b1, pg_vpn[j], asid, mega, mmu_pkg::pte_t'({rnd[31:10], 2'b00, flags})}, '0);
  endtask

  function automatic logic [31:0] page_va(input int j);
    logic [31:0] rnd;
    rnd = $urandom;
    return pg_mega[j] ? {pg_vpn[j][19:10], rnd[21:0]} : {pg_vpn[j], rnd[11:0]};
  endfunction

  task automatic probe_asids();
    for (int a = 3; a < 5; a++) begin
      set_ctrl(1'b1, mmu_pkg::PRIV_S, 1'b0, 1'b0, 9'(a));
      for (int j = 0; j < 4; j++) begin
        lookup(page_va(j), 1'b0);
      end
    end
  endtask

  // two idle cycles let the last response reach the compare
  task automatic end_test(input string name);
    drive('0, '0, '0);
    drive('0, '0, '0);
    $display("%-12s checks %0d, errors %0d", name, checks - mark_checks, errors - mark_errors);
    mark_checks = checks;
    mark_errors = errors;
  endtask

  initial begin
    int          k;
    logic [31:0] rnd;
    void'($urandom(52));
    req    = '0;
    ctrl   = '0;
    refill = '0;
    flush  = '0;
    rst_ni = 1'b0;
    sh_ptr = 0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      sh_valid[i] = 1'b0;
      sh_entry[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    set_ctrl(1'b0, mmu_pkg::PRIV_S, 1'b0, 1'b0, 9'd1);
    repeat (4) lookup($urandom, 1'($urandom));
    set_ctrl(1'b1, mmu_pkg::PRIV_M, 1'b0, 1'b0, 9'd1);
    repeat (4) lookup($urandom, 1'($urandom));
    end_test("bypass");

    set_ctrl(1'b1, mmu_pkg::PRIV_S, 1'b0, 1'b0, 9'd5);
    for (int j = 0; j < 4; j++) begin
      add_page(j, 10'(j + 1), j == 3, 9'd5, F_RWAD);
    end
    repeat (16) lookup(page_va($urandom_range(3)), 1'($urandom));
    end_test("translate");

    flush_tlb(9'd0, 32'd0);
    for (int j = 0; j < 6; j++) begin
      add_page(j, 10'(j + 8), 1'b0, 9'd5, PERM_FLAGS[j]);
    end
    // p sweeps priv, sum and mxr
    for (int p = 0; p < 8; p++) begin
      set_ctrl(1'b1, p[2] ? mmu_pkg::PRIV_S : mmu_pkg::PRIV_U, p[1], p[0], 9'd5);
      for (int j = 0; j < 6; j++) begin
        lookup(page_va(j), 1'b0);
        lookup(page_va(j), 1'b1);
      end
    end
    end_test("permission");

    flush_tlb(9'd0, 32'd0);
    lookup(32'h0badc123, 1'b0);
    for (int j = 0; j < NUM_ENTRIES + 3; j++) begin
      add_page(j, 10'(j + 20), 1'b0, 9'd5, F_RWAD);
    end
    for (int j = 0; j < NUM_ENTRIES + 3; j++) begin
      lookup(page_va(j), 1'b0);
    end
    end_test("replacement");

    flush_tlb(9'd0, 32'd0);
    add_page(0, 10'd30, 1'b0, 9'd3, F_RWAD);
    add_page(1, 10'd31, 1'b0, 9'd3, F_RWAD | 8'h20);
    add_page(2, 10'd32, 1'b0, 9'd4, F_RWAD);
    add_page(3, 10'd33, 1'b1, 9'd3, F_RWAD);
    // same page under a second ASID
    drive('0, '{1'b1, pg_vpn[0], 9'd4, 1'b0, mmu_pkg::pte_t'({22'h3abcd, 2'b00, F_RWAD})}, '0);
    probe_asids();
    flush_tlb(9'd0, {pg_vpn[0], 12'h000});
    probe_asids();
    flush_tlb(9'd3, 32'd0);
    probe_asids();
    flush_tlb(9'd0, 32'd0);
    probe_asids();
    end_test("asid_flush");

    flush_tlb(9'd0, 32'd0);
    set_ctrl(1'b1, mmu_pkg::PRIV_S, 1'b0, 1'b0, 9'd6);
    // lookup of page j in its own refill cycle must miss
    for (int j = 0; j < 12; j++) begin
      rnd        = $urandom;
      pg_vpn[j]  = {10'(j + 40), rnd[9:0]};
      pg_mega[j] = 1'b0;
      k          = (j > 0 && rnd[31]) ? j - 1 : j;
      drive('{1'b1, page_va(k), 1'b0},
            '{1'b1, pg_vpn[j], 9'd6, 1'b0, mmu_pkg::pte_t'({rnd[31:10], 2'b00, F_RWAD})}, '0);
    end
    end_test("back_to_back");

    $display("total checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(PLANNED_REQS * 40 + 1000);
    $display("timeout, the tests did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== verification/mmu_assertions.sv ====
// ----------------------------------------------------------------------
// concurrent checks bound into the TLB resolver
// match vector, response timing, miss and fault exclusion
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module mmu_assertions #(
  parameter int unsigned NUM_ENTRIES = 8
) (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_valid_i,
  input logic [NUM_ENTRIES-1:0] match_i,
  input mmu_pkg::lookup_rsp_t   rsp_i
);

  // entries never overlap, so at most one matches
  match_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(match_i))
    else $error("more than one TLB entry matches");

  rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |=> rsp_i.valid)
    else $error("no response one cycle after a request");

  no_rsp_without_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !req_valid_i |=> !rsp_i.valid)
    else $error("response without a request in the previous cycle");

  miss_no_exc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rsp_i.miss && rsp_i.exc_valid))
    else $error("miss and page fault raised together");

endmodule

bind tlb_resolver mmu_assertions #(
  .NUM_ENTRIES (NUM_ENTRIES)
) i_mmu_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_valid_i (req_i.valid),
  .match_i     (match_i),
  .rsp_i       (rsp_o)
);

// ==== hw/sv32_mmu_top.sv ====
// ----------------------------------------------------------------------
// Sv32 data TLB top level
// refill controller, fully associative entry array and resolver
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module sv32_mmu_top #(
  parameter int unsigned NUM_ENTRIES = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  mmu_pkg::lookup_req_t              req_i,
  input  mmu_pkg::mmu_ctrl_t                ctrl_i,
  input  mmu_pkg::tlb_refill_t              refill_i,
  input  mmu_pkg::tlb_flush_t               flush_i,
  output logic                              hit_o,
  output logic [mmu_pkg::PPN_W-1:0]         ppn_o,
  output mmu_pkg::lookup_rsp_t              rsp_o
);

  logic [NUM_ENTRIES-1:0]                entry_valid;
  logic [NUM_ENTRIES-1:0]                write_en;
  logic [NUM_ENTRIES-1:0]                match;
  mmu_pkg::tlb_content_t [NUM_ENTRIES-1:0] content;

  tlb_refill_ctrl #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) i_refill_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .refill_valid_i (refill_i.valid),
    .entry_valid_i  (entry_valid),
    .write_en_o     (write_en)
  );

  // entry array, all entries see the same refill, flush and lookup
  for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
    tlb_entry i_entry (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .write_en_i    (write_en[i]),
      .refill_i      (refill_i),
      .flush_i       (flush_i),
      .lookup_vpn_i  (req_i.vaddr[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFS_W]),
      .lookup_asid_i (ctrl_i.asid),
      .valid_o       (entry_valid[i]),
      .match_o       (match[i]),
      .content_o     (content[i])
    );
  end

  tlb_resolver #(
    .NUM_ENTRIES (NUM_ENTRIES)
  ) i_resolver (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .ctrl_i    (ctrl_i),
    .match_i   (match),
    .content_i (content),
    .hit_o     (hit_o),
    .ppn_o     (ppn_o),
    .rsp_o     (rsp_o)
  );

endmodule

// ==== hw/tlb_resolver.sv ====
// ----------------------------------------------------------------------
// TLB resolver
// match select, cycle 0 hit/PPN, request register, cycle 1 physical
// address and page fault checks
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tlb_resolver #(
  parameter int unsigned NUM_ENTRIES = 8
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  mmu_pkg::lookup_req_t                    req_i,
  input  mmu_pkg::mmu_ctrl_t                      ctrl_i,
  input  logic [NUM_ENTRIES-1:0]                  match_i,
  input  mmu_pkg::tlb_content_t [NUM_ENTRIES-1:0] content_i,
  output logic                                    hit_o,
  output logic [mmu_pkg::PPN_W-1:0]               ppn_o,
  output mmu_pkg::lookup_rsp_t                    rsp_o
);

  localparam int unsigned SEG      = mmu_pkg::VPN_SEG_W;
  localparam int unsigned OFS      = mmu_pkg::PAGE_OFS_W;
  localparam int unsigned MEGA_OFS = OFS + SEG;

  mmu_pkg::tlb_content_t sel;
  logic                  bypass;
  logic                  tlb_hit;

  // request cycle state carried into the response cycle
  logic                      req_valid_q;
  logic [mmu_pkg::VLEN-1:0]  vaddr_q;
  logic                      is_store_q;
  mmu_pkg::priv_lvl_e        priv_q;
  logic                      sum_q;
  logic                      mxr_q;
  logic                      bypass_q;
  logic                      hit_q;
  mmu_pkg::pte_t             pte_q;
  logic                      is_mega_q;

  logic priv_err;
  logic ld_fault;
  logic st_fault;
  logic fault;

  // ---------------------------------------------------------------------
  // cycle 0
  // ---------------------------------------------------------------------
  // match vector is one-hot or zero, so an OR of the masked contents selects
  always_comb begin
    sel = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      sel = sel | (content_i[i] & {$bits(mmu_pkg::tlb_content_t){match_i[i]}});
    end
  end

  assign bypass  = !ctrl_i.en_translation || (ctrl_i.priv == mmu_pkg::PRIV_M);
  assign tlb_hit = |match_i;
  assign hit_o   = bypass || tlb_hit;

  always_comb begin
    if (bypass) begin
      ppn_o = mmu_pkg::PPN_W'(req_i.vaddr[mmu_pkg::VLEN-1:OFS]);
    end else if (sel.is_mega) begin
      ppn_o = {sel.pte.ppn[mmu_pkg::PPN_W-1:SEG], req_i.vaddr[MEGA_OFS-1:OFS]};
    end else begin
      ppn_o = sel.pte.ppn;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q    <= req_i.vaddr;
    is_store_q <= req_i.is_store;
    priv_q     <= ctrl_i.priv;
    sum_q      <= ctrl_i.sum;
    mxr_q      <= ctrl_i.mxr;
    bypass_q   <= bypass;
    hit_q      <= tlb_hit;
    pte_q      <= sel.pte;
    is_mega_q  <= sel.is_mega;
  end

  // ---------------------------------------------------------------------
  // cycle 1
  // ---------------------------------------------------------------------
  // U-mode needs a user page, S-mode reaches user pages only with SUM
  assign priv_err = ((priv_q == mmu_pkg::PRIV_U) && !pte_q.u) ||
                    ((priv_q == mmu_pkg::PRIV_S) && pte_q.u && !sum_q);

  // MXR makes execute-only pages readable
  assign ld_fault = !pte_q.a || !(pte_q.r || (mxr_q && pte_q.x)) || priv_err;
  assign st_fault = !pte_q.a || !pte_q.w || !pte_q.d || priv_err;
  assign fault    = is_store_q ? st_fault : ld_fault;

  always_comb begin
    rsp_o = '0;
    rsp_o.cause = mmu_pkg::CAUSE_NONE;
    if (req_valid_q) begin
      rsp_o.valid = 1'b1;
      if (bypass_q) begin
        rsp_o.paddr = mmu_pkg::PLEN'(vaddr_q);
      end else if (!hit_q) begin
        // no walker here, the requester refills and retries
        rsp_o.miss = 1'b1;
      end else begin
        if (is_mega_q) begin
          rsp_o.paddr = {pte_q.ppn[mmu_pkg::PPN_W-1:SEG], vaddr_q[MEGA_OFS-1:0]};
        end else begin
          rsp_o.paddr = {pte_q.ppn, vaddr_q[OFS-1:0]};
        end
        if (fault) begin
          rsp_o.exc_valid = 1'b1;
          rsp_o.cause     = is_store_q ? mmu_pkg::CAUSE_ST_PAGE_FAULT
                                       : mmu_pkg::CAUSE_LD_PAGE_FAULT;
        end
      end
    end
  end

endmodule

// ==== hw/tlb_refill_ctrl.sv ====
// ----------------------------------------------------------------------
// TLB refill controller
// victim selection and one-hot entry write enables
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tlb_refill_ctrl #(
  parameter int unsigned NUM_ENTRIES = 8
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   refill_valid_i,
  input  logic [NUM_ENTRIES-1:0] entry_valid_i,
  output logic [NUM_ENTRIES-1:0] write_en_o
);

  localparam int unsigned IDX_W = $clog2(NUM_ENTRIES);

  logic             array_full;
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] victim_idx;
  logic [IDX_W-1:0] rr_ptr_q;

  assign array_full = &entry_valid_i;

  // priority encoder, lowest invalid entry wins
  always_comb begin
    free_idx = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!entry_valid_i[i]) begin
        free_idx = IDX_W'(i);
      end
    end
  end

  assign victim_idx = array_full ? rr_ptr_q : free_idx;

  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      write_en_o[i] = refill_valid_i && (victim_idx == IDX_W'(i));
    end
  end

  // ---------------------------------------------------------------------
  // round-robin pointer
  // ---------------------------------------------------------------------
  // only moves when a valid entry gets replaced
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_ptr_q <= '0;
    end else if (refill_valid_i && array_full) begin
      if (rr_ptr_q == IDX_W'(NUM_ENTRIES - 1)) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= rr_ptr_q + 1'b1;
      end
    end
  end

endmodule

// ==== hw/tlb_entry.sv ====
// ----------------------------------------------------------------------
// single fully associative TLB entry
// tag and PTE storage, flush matching, lookup compare
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tlb_entry (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        write_en_i,
  input  mmu_pkg::tlb_refill_t        refill_i,
  input  mmu_pkg::tlb_flush_t         flush_i,
  input  logic [mmu_pkg::VPN_W-1:0]   lookup_vpn_i,
  input  logic [mmu_pkg::ASID_W-1:0]  lookup_asid_i,
  output logic                        valid_o,
  output logic                        match_o,
  output mmu_pkg::tlb_content_t       content_o
);

  localparam int unsigned SEG = mmu_pkg::VPN_SEG_W;

  logic                       valid_q;
  logic [mmu_pkg::VPN_W-1:0]  vpn_q;
  logic [mmu_pkg::ASID_W-1:0] asid_q;
  logic                       is_mega_q;
  mmu_pkg::pte_t              pte_q;

  logic [mmu_pkg::VPN_W-1:0]  flush_vpn;
  logic                       flush_asid_hit;
  logic                       flush_vpn_hit;
  logic                       flush_hit;
  logic                       lookup_vpn_hit;

  // ---------------------------------------------------------------------
  // flush matching
  // ---------------------------------------------------------------------
  assign flush_vpn = flush_i.vaddr[mmu_pkg::VLEN-1:mmu_pkg::PAGE_OFS_W];

  // global pages survive an ASID-specific flush
  assign flush_asid_hit = (flush_i.asid == '0) || ((flush_i.asid == asid_q) && !pte_q.g);

  // megapages ignore the low VPN segment
  assign flush_vpn_hit = (flush_i.vaddr == '0) ||
                         ((flush_vpn[2*SEG-1:SEG] == vpn_q[2*SEG-1:SEG]) &&
                          (is_mega_q || (flush_vpn[SEG-1:0] == vpn_q[SEG-1:0])));

  assign flush_hit = flush_i.valid && flush_asid_hit && flush_vpn_hit;

  // ---------------------------------------------------------------------
  // lookup compare
  // ---------------------------------------------------------------------
  assign lookup_vpn_hit = (lookup_vpn_i[2*SEG-1:SEG] == vpn_q[2*SEG-1:SEG]) &&
                          (is_mega_q || (lookup_vpn_i[SEG-1:0] == vpn_q[SEG-1:0]));

  assign match_o = valid_q && (pte_q.g || (lookup_asid_i == asid_q)) && lookup_vpn_hit;

  assign valid_o           = valid_q;
  assign content_o.pte     = pte_q;
  assign content_o.is_mega = is_mega_q;

  // refill takes priority so a same-cycle flush cannot drop a new entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (write_en_i) begin
      valid_q <= 1'b1;
    end else if (flush_hit) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_en_i) begin
      vpn_q     <= refill_i.vpn;
      asid_q    <= refill_i.asid;
      is_mega_q <= refill_i.is_mega;
      pte_q     <= refill_i.pte;
    end
  end

endmodule

// ==== hw/mmu_pkg.sv ====
// ----------------------------------------------------------------------
// Sv32 data-side translation unit types
// address widths, PTE layout, request/response, refill and flush
// structs, privilege and exception cause enums
// ----------------------------------------------------------------------

package mmu_pkg;

  // address widths
  localparam int unsigned VLEN       = 32;
  localparam int unsigned PLEN       = 34;
  localparam int unsigned VPN_W      = 20;
  localparam int unsigned VPN_SEG_W  = 10;
  localparam int unsigned PPN_W      = 22;
  localparam int unsigned PAGE_OFS_W = 12;
  localparam int unsigned ASID_W     = 9;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  typedef enum logic [3:0] {
    CAUSE_NONE          = 4'd0,
    CAUSE_LD_PAGE_FAULT = 4'd13,
    CAUSE_ST_PAGE_FAULT = 4'd15
  } exc_cause_e;

  // Sv32 page table entry, bit 0 is V
  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } pte_t;

  typedef struct packed {
    logic              valid;
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
    logic              is_mega;
    pte_t              pte;
  } tlb_refill_t;

  // zero asid flushes all address spaces, zero vaddr flushes all pages
  typedef struct packed {
    logic              valid;
    logic [ASID_W-1:0] asid;
    logic [VLEN-1:0]   vaddr;
  } tlb_flush_t;

  typedef struct packed {
    pte_t pte;
    logic is_mega;
  } tlb_content_t;

  typedef struct packed {
    logic            valid;
    logic [VLEN-1:0] vaddr;
    logic            is_store;
  } lookup_req_t;

  typedef struct packed {
    logic              en_translation;
    priv_lvl_e         priv;
    logic              sum;
    logic              mxr;
    logic [ASID_W-1:0] asid;
  } mmu_ctrl_t;

  typedef struct packed {
    logic            valid;
    logic            miss;
    logic [PLEN-1:0] paddr;
    logic            exc_valid;
    exc_cause_e      cause;
  } lookup_rsp_t;

endpackage
